// File: verilog/mmu_pkg.sv
/*
  mmu architecture package
  SRMMU-style formats shared by the TLB blocks: virtual address split,
  context number and page table entry layout
*/

package mmu_pkg;

  // ----------------------------------------
  // address geometry
  // ----------------------------------------
  localparam int VADDR_W       = 32;
  localparam int PAGE_OFFSET_W = 12;
  localparam int VPN_W         = VADDR_W - PAGE_OFFSET_W;
  localparam int CTX_W         = 8;

  // entry type code of a leaf translation
  localparam logic [1:0] ET_PTE = 2'd2;

  typedef logic [CTX_W-1:0] mmu_ctx_t;

  // 4 KB page split of a virtual address
  typedef struct packed {
    logic [VPN_W-1:0]         vpn;
    logic [PAGE_OFFSET_W-1:0] offset;
  } mmu_vaddr_t;

  // page table entry, msb first
  typedef struct packed {
    logic [23:0] ppn;
    logic        c;
    logic        m;
    logic        r;
    logic [2:0]  acc;
    logic [1:0]  et;
  } mmu_pte_t;

endpackage

// File: verilog/dtlb_pkg.sv
/*
  dtlb organization package
  way and set geometry of the data TLB and the structs passed between
  the access controller, the ways and the hit merger
*/

package dtlb_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int NWAYS   = 2;
  localparam int NSETS   = 16;
  localparam int WAY_W   = $clog2(NWAYS);
  localparam int INDEX_W = $clog2(NSETS);
  // tag is what is left of the vpn above the set index
  localparam int TAG_W   = $bits(mmu_pkg::mmu_vaddr_t) - mmu_pkg::PAGE_OFFSET_W - INDEX_W;

  typedef logic [INDEX_W-1:0] dtlb_index_t;
  typedef logic [TAG_W-1:0]   dtlb_tag_t;
  typedef logic [WAY_W-1:0]   dtlb_way_t;

  typedef struct packed {
    dtlb_tag_t         tag;
    mmu_pkg::mmu_ctx_t ctx;
    mmu_pkg::mmu_pte_t pte;
  } dtlb_entry_t;

  // lookup from the pipeline, address already split
  typedef struct packed {
    logic              valid;
    dtlb_index_t       index;
    dtlb_tag_t         tag;
    mmu_pkg::mmu_ctx_t ctx;
  } dtlb_req_t;

  // refill from the table walker
  typedef struct packed {
    logic              valid;
    dtlb_index_t       index;
    dtlb_tag_t         tag;
    mmu_pkg::mmu_ctx_t ctx;
    mmu_pkg::mmu_pte_t pte;
  } dtlb_refill_t;

  // broadcast to every way, write enables travel separately
  typedef struct packed {
    dtlb_req_t   rd;
    dtlb_index_t wr_index;
    dtlb_entry_t wr_entry;
  } dtlb_way_cmd_t;

  // way result, also carries the registered request of that way
  typedef struct packed {
    logic              hit;
    mmu_pkg::mmu_pte_t pte;
    logic              req_valid;
    dtlb_index_t       req_index;
  } dtlb_way_res_t;

  typedef struct packed {
    logic        valid;
    dtlb_index_t index;
    dtlb_way_t   way;
  } dtlb_lru_upd_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    mmu_pkg::mmu_pte_t pte;
  } dtlb_resp_t;

endpackage

// File: verilog/dtlb_access_ctrl.sv
/*
  dtlb access controller
  turns lookups and refills into the way command, picks the refill way
  from the per-set LRU bit and keeps those bits current
*/

module dtlb_access_ctrl (
  input  bit                       gclk,
  input  bit                       rst_n,
  input  dtlb_pkg::dtlb_req_t      lookup,
  input  dtlb_pkg::dtlb_refill_t   refill,
  input  dtlb_pkg::dtlb_lru_upd_t  lru_upd,
  output dtlb_pkg::dtlb_way_cmd_t  way_cmd,
  output logic [dtlb_pkg::NWAYS-1:0] way_we
);

  import mmu_pkg::*;
  import dtlb_pkg::*;

  // way to replace next, one per set
  dtlb_way_t lru [NSETS];

  logic      refill_ok;
  dtlb_way_t victim;

  // ----------------------------------------
  // way command
  // ----------------------------------------

  // only leaf translations are cached
  assign refill_ok = refill.valid && (refill.pte.et == ET_PTE);
  assign victim    = lru[refill.index];

  always_comb begin
    way_cmd.rd           = lookup;
    way_cmd.wr_index     = refill.index;
    way_cmd.wr_entry.tag = refill.tag;
    way_cmd.wr_entry.ctx = refill.ctx;
    way_cmd.wr_entry.pte = refill.pte;
  end

  always_comb begin
    way_we = '0;
    if (refill_ok) begin
      way_we[victim] = 1'b1;
    end
  end

  // ----------------------------------------
  // lru bits
  // ----------------------------------------

  always_ff @(posedge gclk) begin
    if (!rst_n) begin
      lru <= '{default: '0};
    end else begin
      // hit way becomes most recently used
      if (lru_upd.valid) begin
        lru[lru_upd.index] <= ~lru_upd.way;
      end
      // refill to the same set overrides the hit update
      if (refill_ok) begin
        lru[refill.index] <= ~victim;
      end
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // a single way takes each refill
  a_we_onehot: assert property (
    @(posedge gclk) disable iff (!rst_n)
    $onehot0(way_we)
  ) else $error("more than one way write enable set");

endmodule

// File: verilog/dtlb_way.sv
/*
  dtlb way
  one set-indexed way of the TLB: entry storage with per-set valid bits,
  synchronous read and tag/context compare in the following cycle
*/

module dtlb_way (
  input  bit                      gclk,
  input  bit                      rst_n,
  input  dtlb_pkg::dtlb_way_cmd_t way_cmd,
  input  bit                      we,
  output dtlb_pkg::dtlb_way_res_t res
);

  import mmu_pkg::*;
  import dtlb_pkg::*;

  dtlb_entry_t      mem [NSETS];
  logic [NSETS-1:0] vld;

  // registered read side
  dtlb_req_t   req_q;
  dtlb_entry_t ent_q;
  logic        ent_vld_q;

  // ----------------------------------------
  // storage
  // ----------------------------------------

  always_ff @(posedge gclk) begin
    if (we) begin
      mem[way_cmd.wr_index] <= way_cmd.wr_entry;
    end
    // read sees the contents before this edge's write
    ent_q <= mem[way_cmd.rd.index];
  end

  always_ff @(posedge gclk) begin
    if (!rst_n) begin
      vld       <= '0;
      ent_vld_q <= 1'b0;
    end else begin
      if (we) begin
        vld[way_cmd.wr_index] <= 1'b1;
      end
      ent_vld_q <= vld[way_cmd.rd.index];
    end
  end

  // request held for the compare cycle
  always_ff @(posedge gclk) begin
    if (!rst_n) begin
      req_q.valid <= 1'b0;
    end else begin
      req_q.valid <= way_cmd.rd.valid;
    end
    req_q.index <= way_cmd.rd.index;
    req_q.tag   <= way_cmd.rd.tag;
    req_q.ctx   <= way_cmd.rd.ctx;
  end

  // ----------------------------------------
  // compare
  // ----------------------------------------

  always_comb begin
    res.hit       = req_q.valid && ent_vld_q &&
                    (ent_q.tag == req_q.tag) && (ent_q.ctx == req_q.ctx);
    res.pte       = ent_q.pte;
    res.req_valid = req_q.valid;
    res.req_index = req_q.index;
  end

endmodule

// File: verilog/dtlb_hit_merge.sv
/*
  dtlb hit merger
  combines the way results into the registered lookup response and
  reports the hitting way to the LRU logic
*/

module dtlb_hit_merge (
  input  bit                      gclk,
  input  bit                      rst_n,
  input  dtlb_pkg::dtlb_way_res_t way_res [dtlb_pkg::NWAYS],
  output dtlb_pkg::dtlb_lru_upd_t lru_upd,
  output dtlb_pkg::dtlb_resp_t    resp
);

  import mmu_pkg::*;
  import dtlb_pkg::*;

  logic [NWAYS-1:0] hits;
  logic             any_hit;
  dtlb_way_t        hit_way;
  mmu_pte_t         hit_pte;

  // ----------------------------------------
  // way select
  // ----------------------------------------

  always_comb begin
    hit_way = '0;
    hit_pte = way_res[0].pte;
    // walk down so the lowest hitting way wins
    for (int w = NWAYS - 1; w >= 0; w--) begin
      hits[w] = way_res[w].hit;
      if (way_res[w].hit) begin
        hit_way = dtlb_way_t'(w);
        hit_pte = way_res[w].pte;
      end
    end
  end

  assign any_hit = |hits;

  // request fields come from way 0's pipeline copy
  always_comb begin
    lru_upd.valid = any_hit;
    lru_upd.index = way_res[0].req_index;
    lru_upd.way   = hit_way;
  end

  // ----------------------------------------
  // response register
  // ----------------------------------------

  always_ff @(posedge gclk) begin
    if (!rst_n) begin
      resp.valid <= 1'b0;
    end else begin
      resp.valid <= way_res[0].req_valid;
    end
    resp.hit <= any_hit;
    resp.pte <= hit_pte;
  end

  // an entry lives in one way only
  a_single_hit: assert property (
    @(posedge gclk) disable iff (!rst_n)
    $onehot0(hits)
  ) else $error("translation hit in more than one way");

endmodule

// File: verilog/dtlb_top.sv
/*
  dtlb top
  two-way data TLB for 4 KB pages: access controller, generated ways
  and hit merger, one lookup per cycle with a one-cycle answer
*/

module dtlb_top (
  input  bit                     gclk,
  input  bit                     rst_n,
  input  dtlb_pkg::dtlb_req_t    lookup,
  input  dtlb_pkg::dtlb_refill_t refill,
  output dtlb_pkg::dtlb_resp_t   resp
);

  import dtlb_pkg::*;

  dtlb_way_cmd_t    way_cmd;
  logic [NWAYS-1:0] way_we;
  dtlb_way_res_t    way_res [NWAYS];
  dtlb_lru_upd_t    lru_upd;

  dtlb_access_ctrl u_ctrl (
    .gclk    (gclk),
    .rst_n   (rst_n),
    .lookup  (lookup),
    .refill  (refill),
    .lru_upd (lru_upd),
    .way_cmd (way_cmd),
    .way_we  (way_we)
  );

  // ----------------------------------------
  // ways
  // ----------------------------------------
  for (genvar i = 0; i < NWAYS; i++) begin : g_way
    dtlb_way u_way (
      .gclk    (gclk),
      .rst_n   (rst_n),
      .way_cmd (way_cmd),
      .we      (way_we[i]),
      .res     (way_res[i])
    );
  end

  dtlb_hit_merge u_merge (
    .gclk    (gclk),
    .rst_n   (rst_n),
    .way_res (way_res),
    .lru_upd (lru_upd),
    .resp    (resp)
  );

endmodule

// File: bench/dtlb_vectors.svh
/*
  dtlb test vectors
  lookup and refill rows with the hit and pte expected from each
  lookup, applied in order by the testbench
*/

`ifndef DTLB_VECTORS_SVH
`define DTLB_VECTORS_SVH

typedef enum logic [1:0] {
  OP_IDLE,
  OP_LOOKUP,
  OP_REFILL
} vec_op_e;

typedef struct packed {
  vec_op_e  op;
  logic [3:0]  index;
  logic [15:0] tag;
  mmu_pkg::mmu_ctx_t ctx;
  mmu_pkg::mmu_pte_t pte;
  logic     exp_hit;
  mmu_pkg::mmu_pte_t exp_pte;
} vec_t;

localparam int NUM_VECS = 32;

// columns: op, index, tag, ctx, pte, expected hit, expected pte
// pte low byte is c m r acc[2:0] et[1:0], et 2 marks a translation
localparam vec_t VECS [NUM_VECS] = '{
  '{OP_LOOKUP, 4'h3, 16'h1234, 8'h05, 32'h0000_0000, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h0, 16'h0000, 8'h00, 32'h0000_0000, 1'b0, 32'h0000_0000},
  '{OP_REFILL, 4'h1, 16'hA001, 8'h05, 32'h0000_1A2E, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h1, 16'hA001, 8'h05, 32'h0000_0000, 1'b1, 32'h0000_1A2E},
  '{OP_LOOKUP, 4'h1, 16'hA001, 8'h06, 32'h0000_0000, 1'b0, 32'h0000_0000},
  '{OP_REFILL, 4'h2, 16'hB001, 8'h01, 32'h0000_2B0E, 1'b0, 32'h0000_0000},
  '{OP_REFILL, 4'h2, 16'hB002, 8'h01, 32'h0000_2B1E, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h2, 16'hB001, 8'h01, 32'h0000_0000, 1'b1, 32'h0000_2B0E},
  '{OP_LOOKUP, 4'h2, 16'hB002, 8'h01, 32'h0000_0000, 1'b1, 32'h0000_2B1E},
  '{OP_REFILL, 4'h2, 16'hB003, 8'h01, 32'h0000_2B2E, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h2, 16'hB001, 8'h01, 32'h0000_0000, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h2, 16'hB002, 8'h01, 32'h0000_0000, 1'b1, 32'h0000_2B1E},
  '{OP_LOOKUP, 4'h2, 16'hB003, 8'h01, 32'h0000_0000, 1'b1, 32'h0000_2B2E},
  '{OP_REFILL, 4'h4, 16'hC001, 8'h02, 32'h0000_3C0A, 1'b0, 32'h0000_0000},
  '{OP_REFILL, 4'h4, 16'hC002, 8'h02, 32'h0000_3C1A, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h4, 16'hC001, 8'h02, 32'h0000_0000, 1'b1, 32'h0000_3C0A},
  '{OP_REFILL, 4'h4, 16'hC003, 8'h02, 32'h0000_3C2A, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h4, 16'hC001, 8'h02, 32'h0000_0000, 1'b1, 32'h0000_3C0A},
  '{OP_LOOKUP, 4'h4, 16'hC002, 8'h02, 32'h0000_0000, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h4, 16'hC003, 8'h02, 32'h0000_0000, 1'b1, 32'h0000_3C2A},
  '{OP_REFILL, 4'h5, 16'hD002, 8'h03, 32'h0000_4D12, 1'b0, 32'h0000_0000},
  '{OP_REFILL, 4'h5, 16'hD001, 8'h03, 32'h0000_4D01, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h5, 16'hD001, 8'h03, 32'h0000_0000, 1'b0, 32'h0000_0000},
  '{OP_REFILL, 4'h5, 16'hD003, 8'h03, 32'h0000_4D22, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h5, 16'hD002, 8'h03, 32'h0000_0000, 1'b1, 32'h0000_4D12},
  '{OP_LOOKUP, 4'h5, 16'hD003, 8'h03, 32'h0000_0000, 1'b1, 32'h0000_4D22},
  '{OP_REFILL, 4'h0, 16'hE000, 8'h07, 32'h0000_5E06, 1'b0, 32'h0000_0000},
  '{OP_REFILL, 4'hF, 16'hE00F, 8'h07, 32'h0000_5F0E, 1'b0, 32'h0000_0000},
  '{OP_LOOKUP, 4'h0, 16'hE000, 8'h07, 32'h0000_0000, 1'b1, 32'h0000_5E06},
  '{OP_LOOKUP, 4'hF, 16'hE00F, 8'h07, 32'h0000_0000, 1'b1, 32'h0000_5F0E},
  '{OP_LOOKUP, 4'h7, 16'hE000, 8'h07, 32'h0000_0000, 1'b0, 32'h0000_0000},
  '{OP_IDLE,   4'h0, 16'h0000, 8'h00, 32'h0000_0000, 1'b0, 32'h0000_0000}
};

`endif

// File: bench/dtlb_tb.sv
/*
  dtlb testbench
  applies the vector table to the TLB top level, one row every three
  cycles, and checks each lookup response one cycle after sampling
*/

module dtlb_tb;

  import mmu_pkg::*;
  import dtlb_pkg::*;

  `include "dtlb_vectors.svh"

  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DLY    = 2;
  localparam int CYCLE_LIMIT  = NUM_VECS * 3 + RESET_CYCLES + 20;

  logic         gclk;
  logic         rst_n;
  dtlb_req_t    lookup;
  dtlb_refill_t refill;
  dtlb_resp_t   resp;

  int cycle_cnt  = 0;
  int hit_errs   = 0;
  int pte_errs   = 0;
  int valid_errs = 0;
  int total_errs = 0;

  dtlb_top dut0 (
    .gclk   (gclk),
    .rst_n  (rst_n),
    .lookup (lookup),
    .refill (refill),
    .resp   (resp)
  );

  initial begin
    gclk = 1'b0;
    forever #20 gclk = ~gclk;
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  task automatic drive_idle();
    lookup = '0;
    refill = '0;
  endtask

  task automatic apply_row(input vec_t v);
    drive_idle();
    case (v.op)
      OP_LOOKUP: begin
        lookup.valid = 1'b1;
        lookup.index = v.index;
        lookup.tag   = v.tag;
        lookup.ctx   = v.ctx;
      end
      OP_REFILL: begin
        refill.valid = 1'b1;
        refill.index = v.index;
        refill.tag   = v.tag;
        refill.ctx   = v.ctx;
        refill.pte   = v.pte;
      end
      default: begin
      end
    endcase
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------

  task automatic check_valid(input bit got, input bit exp, input int row);
    if (got && !exp) begin
      $display("unexpected response valid in an idle cycle near row %0d", row);
      valid_errs++;
    end else if (!got && exp) begin
      $display("no response valid one cycle after the lookup of row %0d", row);
      valid_errs++;
    end
  endtask

  task automatic check_hit(input bit got, input bit exp, input int row);
    if (got != exp) begin
      $display("Fail at %0t: row %0d hit is %0b, expected %0b", $time, row, got, exp);
      hit_errs++;
    end
  endtask

  task automatic check_pte(input mmu_pte_t got, input mmu_pte_t exp, input int row);
    if (got != exp) begin
      $display("Fail at %0t: row %0d pte is %h (ppn %h et %0d), expected %h",
               $time, row, got, got.ppn, got.et, exp);
      pte_errs++;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    rst_n = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge gclk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    for (int r = 0; r < NUM_VECS; r++) begin
      apply_row(VECS[r]);
      // row sampled at this edge
      @(posedge gclk);
      #DRIVE_DLY;
      drive_idle();
      check_valid(resp.valid, 1'b0, r);
      // response registered one edge later
      @(posedge gclk);
      #DRIVE_DLY;
      if (VECS[r].op == OP_LOOKUP) begin
        check_valid(resp.valid, 1'b1, r);
        if (resp.valid) begin
          check_hit(resp.hit, VECS[r].exp_hit, r);
          if (VECS[r].exp_hit) begin
            check_pte(resp.pte, VECS[r].exp_pte, r);
          end
        end
      end else begin
        check_valid(resp.valid, 1'b0, r);
      end
      // lets the lru update settle
      @(posedge gclk);
      #DRIVE_DLY;
      // response valid lasts a single cycle
      check_valid(resp.valid, 1'b0, r);
    end

    total_errs = hit_errs + pte_errs + valid_errs;
    $display("errors: %0d hit, %0d pte, %0d valid over %0d rows",
             hit_errs, pte_errs, valid_errs, NUM_VECS);
    if (total_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // run limit from the table length
  always @(posedge gclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+bench
verilog/mmu_pkg.sv
verilog/dtlb_pkg.sv
verilog/dtlb_access_ctrl.sv
verilog/dtlb_way.sv
verilog/dtlb_hit_merge.sv
verilog/dtlb_top.sv
bench/dtlb_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module dtlb_tb -f verilog.f -Mdir obj_dir
	out="$$(./obj_dir/Vdtlb_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
